//--- flist.f
+incdir+hw
hw/alu_pkg.sv
hw/alu_apb_regs.sv
hw/alu_operand_select.sv
hw/alu_exec.sv
hw/alu_flag_gen.sv
hw/alu_core.sv
hw/alu_apb_top.sv
tests/alu_asserts.sv
tests/alu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = alu_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/alu_tb.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_tb;
  import alu_pkg::*;

  localparam int num_ops     = 220;
  localparam int cycle_limit = 40 * num_ops + 200;  // 40 cycles per op plus margin

  logic                   clk;
  logic                   rst;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`ALU_APB_AW-1:0] paddr;
  logic [`ALU_APB_DW-1:0] pwdata;
  logic [`ALU_APB_DW-1:0] prdata;
  logic                   pready;
  logic                   pslverr;
  logic [`ALU_APB_DW-1:0] rd_data;
  alu_result_t            last_exp;
  alu_result_t            last_got;
  alu_result_t            got_q[$];
  alu_result_t            exp_q[$];
  event                   read_ev;
  int                     cycles = 0;
  alu_opcode_e            op_list[8] = '{op_add, op_sub, op_shr, op_shl,
                                         op_mul, op_cmp, op_inc, op_dec};

  alu_apb_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Done: errors found");
      $fatal(1, "timeout, run did not finish within %0d cycles", cycle_limit);
    end
  end

  task automatic check_value(input string name, input logic [`ALU_DW-1:0] got, exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic check_flags(input string name, input alu_flags_t got, exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1, "flag check failed");
    end
  endtask

  task automatic check_slverr(input logic [`ALU_APB_AW-1:0] addr, input logic got, exp);
    if (got !== exp) begin
      $display("mismatch at %0t: pslverr at 0x%h got %b expected %b", $time, addr, got, exp);
      $display("Done: errors found");
      $fatal(1, "error response check failed");
    end
  endtask

  function automatic alu_result_t alu_model(input alu_operands_t o, input alu_cmd_t c);
    logic [`ALU_DW-1:0]   a;
    logic [`ALU_DW-1:0]   b;
    logic [`ALU_DW-1:0]   r;
    logic [`ALU_DW-1:0]   ref_v;
    logic [2*`ALU_DW-1:0] prod;
    logic                 imm_zero;
    alu_result_t          res;
    imm_zero = (o.imm == '0);
    a        = imm_zero ? o.acc : o.imm;
    b        = c.ra ? o.y : o.x;
    ref_v    = a;
    prod     = a * b;
    res      = '0;
    case (c.opcode)
      op_add:         r = a + b;
      op_sub, op_cmp: r = imm_zero ? o.acc - b : b - o.imm;
      op_shr:         r = imm_zero ? o.acc >> b : b >> o.imm;
      op_shl:         r = imm_zero ? o.acc << b : b << o.imm;
      op_mul:         r = prod[`ALU_DW-1:0];
      op_inc:         r = b + `ALU_DW'd1;
      op_dec:         r = b - `ALU_DW'd1;
      default:        r = '0;
    endcase
    if (c.opcode == op_inc || c.opcode == op_dec) begin
      ref_v = `ALU_DW'd1;  // sign 0
    end
    res.value          = r;
    res.flags.negative = r[`ALU_DW-1];
    res.flags.zero     = (r == '0);
    if (c.opcode != op_shr && c.opcode != op_shl) begin
      res.flags.overflow = (ref_v[`ALU_DW-1] == b[`ALU_DW-1]) &&
                           (r[`ALU_DW-1] != ref_v[`ALU_DW-1]);
      res.flags.carry    = (c.opcode inside {op_add, op_mul, op_inc}) ? (r < ref_v) : (r > ref_v);
    end
    return res;
  endfunction

  task automatic apb_xfer(input logic wr, input logic [`ALU_APB_AW-1:0] addr,
                          input logic [`ALU_APB_DW-1:0] wdata, input logic exp_err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    while (!pready) begin
      @(negedge clk);  // bounded by the cycle counter
    end
    rd_data = prdata;  // stable mid-cycle
    check_slverr(addr, pslverr, exp_err);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_result();
    apb_xfer(1'b0, `ALU_REG_RESULT, '0, 1'b0);
    last_got.value = rd_data[`ALU_DW-1:0];
    check_value("prdata[31:16]", rd_data[`ALU_APB_DW-1:`ALU_DW], '0);  // zero-extended
    apb_xfer(1'b0, `ALU_REG_FLAGS, '0, 1'b0);
    last_got.flags = rd_data[3:0];
    check_value("prdata[31:16]", rd_data[`ALU_APB_DW-1:`ALU_DW], '0);
    check_value("prdata[15:4]", `ALU_DW'(rd_data[`ALU_DW-1:4]), '0);
    got_q.push_back(last_got);
    exp_q.push_back(last_exp);
    -> read_ev;
  endtask

  task automatic run_case(input alu_operands_t o, input alu_cmd_t c);
    logic [`ALU_APB_DW-1:0] cmd_word;
    cmd_word                  = '0;
    cmd_word[5:0]             = c.opcode;
    cmd_word[`ALU_CMD_RA_BIT] = c.ra;
    apb_xfer(1'b1, `ALU_REG_ACC, 32'(o.acc), 1'b0);
    apb_xfer(1'b1, `ALU_REG_X, 32'(o.x), 1'b0);
    apb_xfer(1'b1, `ALU_REG_Y, 32'(o.y), 1'b0);
    apb_xfer(1'b1, `ALU_REG_IMM, 32'(o.imm), 1'b0);
    apb_xfer(1'b1, `ALU_REG_CMD, cmd_word, 1'b0);
    last_exp = alu_model(o, c);
    read_result();
  endtask

  initial begin
    alu_result_t got;
    alu_result_t exp;
    forever begin
      @(read_ev);
      while (got_q.size() > 0) begin
        got = got_q.pop_front();
        exp = exp_q.pop_front();
        check_value("result", got.value, exp.value);
        check_flags("flags", got.flags, exp.flags);
      end
    end
  end

  initial begin
    alu_operands_t o;
    alu_cmd_t      c;
    int            i;
    void'($urandom(32'h6cb2_693e));
    rst      = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    last_exp = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b1;
    read_result();  // zero after reset

    run_case({16'h7FFF, 16'h0001, 16'h0000, 16'h0000}, {op_add, 1'b0});
    run_case({16'hFFFF, 16'h0001, 16'h0000, 16'h0000}, {op_add, 1'b0});
    run_case({16'h0001, 16'h0002, 16'h0000, 16'h0000}, {op_sub, 1'b0});
    run_case({16'h0005, 16'h0000, 16'h0005, 16'h0000}, {op_sub, 1'b1});
    run_case({16'h0000, 16'hFFFF, 16'h0000, 16'h0000}, {op_inc, 1'b0});
    run_case({16'h1234, 16'h0000, 16'h0000, 16'h0000}, {op_dec, 1'b0});
    run_case({16'h0100, 16'h0100, 16'h0000, 16'h0000}, {op_mul, 1'b0});
    read_result();
    read_result();  // held across reads

    run_case({16'h0100, 16'h0010, 16'h0000, 16'h0000}, {op_sub, 1'b0});
    check_value("result", last_got.value, 16'h00F0);  // acc - x
    run_case({16'h0100, 16'h0010, 16'h0000, 16'h0003}, {op_sub, 1'b0});
    check_value("result", last_got.value, 16'h000D);  // x - imm
    run_case({16'h0100, 16'h0004, 16'h0000, 16'h0000}, {op_shr, 1'b0});
    check_value("result", last_got.value, 16'h0010);
    run_case({16'h0100, 16'h0000, 16'h00F0, 16'h0004}, {op_shr, 1'b1});
    check_value("result", last_got.value, 16'h000F);
    run_case({16'h0100, 16'h0003, 16'h0000, 16'h0002}, {op_shl, 1'b0});
    check_value("result", last_got.value, 16'h000C);

    apb_xfer(1'b1, `ALU_REG_CMD, 32'h0000_0012, 1'b1);  // divide
    apb_xfer(1'b1, `ALU_REG_CMD, 32'h0000_0113, 1'b1);  // modulo, ra set
    apb_xfer(1'b1, `ALU_REG_RESULT, 32'h0000_5A5A, 1'b1);
    apb_xfer(1'b0, 8'h1C, '0, 1'b1);
    apb_xfer(1'b1, 8'h40, 32'h0000_FFFF, 1'b1);
    read_result();  // last shift result still there

    for (i = 0; i < 200; i++) begin
      o.acc = `ALU_DW'($urandom() >> ($urandom_range(1) * 28));
      o.x   = `ALU_DW'($urandom() >> ($urandom_range(1) * 28));
      o.y   = `ALU_DW'($urandom() >> ($urandom_range(1) * 28));
      case ($urandom_range(2))
        0:       o.imm = '0;
        1:       o.imm = `ALU_DW'($urandom_range(15, 1));
        default: o.imm = `ALU_DW'($urandom_range(16'hFFFF, 1));
      endcase
      c.opcode = op_list[$urandom_range(7)];
      c.ra     = 1'($urandom_range(1));
      run_case(o, c);
    end

    @(posedge clk);
    #1;
    if (got_q.size() != 0 || dut_i.regs_i.asserts_i.fail_count != 0) begin
      $display("Done: errors found");
      $fatal(1, "reads left unchecked or assertions failed");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

//--- tests/alu_asserts.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_asserts (
  input logic                   clk,
  input logic                   rst,
  input logic                   psel,
  input logic                   penable,
  input logic                   pwrite,
  input logic [`ALU_APB_AW-1:0] paddr,
  input logic                   pready,
  input logic                   pslverr,
  input logic                   launch
);

  int unsigned fail_count = 0;  // read by the testbench at the end

  pready_high: assert property (@(posedge clk) disable iff (!rst) pready)
    else begin
      fail_count++;
      $error("pready went low");
    end

  launch_single: assert property (@(posedge clk) disable iff (!rst) launch |=> !launch)
    else begin
      fail_count++;
      $error("launch held for more than one cycle");
    end

  // launch must come out of the access phase that follows a CMD write setup
  launch_on_cmd: assert property (@(posedge clk) disable iff (!rst)
    launch |-> $past(psel && !penable && pwrite && paddr == `ALU_REG_CMD))
    else begin
      fail_count++;
      $error("launch without a command write");
    end

  slverr_access: assert property (@(posedge clk) disable iff (!rst)
    pslverr |-> (psel && penable && $past(psel && !penable)))
    else begin
      fail_count++;
      $error("pslverr outside an access phase");
    end

endmodule

bind alu_apb_regs alu_asserts asserts_i (
  .clk     (clk),
  .rst     (rst),
  .psel    (psel),
  .penable (penable),
  .pwrite  (pwrite),
  .paddr   (paddr),
  .pready  (pready),
  .pslverr (pslverr),
  .launch  (launch)
);

//--- hw/alu_apb_top.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_apb_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`ALU_APB_AW-1:0] paddr,
  input  logic [`ALU_APB_DW-1:0] pwdata,
  output logic [`ALU_APB_DW-1:0] prdata,
  output logic                   pready,
  output logic                   pslverr
);
  import alu_pkg::*;

  alu_operands_t operands;
  alu_cmd_t      cmd;
  logic          launch;
  alu_result_t   result;

  alu_apb_regs regs_i (
    .clk      (clk),
    .rst      (rst),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .operands (operands),
    .cmd      (cmd),
    .launch   (launch),
    .result   (result)
  );

  alu_core core_i (
    .clk      (clk),
    .rst      (rst),
    .operands (operands),
    .cmd      (cmd),
    .launch   (launch),
    .result   (result)
  );

endmodule

//--- hw/alu_core.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_core (
  input  logic                   clk,
  input  logic                   rst,
  input  alu_pkg::alu_operands_t operands,
  input  alu_pkg::alu_cmd_t      cmd,
  input  logic                   launch,
  output alu_pkg::alu_result_t   result
);
  import alu_pkg::*;

  alu_opnd_t          opnd;
  logic [`ALU_DW-1:0] value;
  alu_flags_t         flags;
  alu_result_t        result_q;

  alu_operand_select opsel_i (
    .operands (operands),
    .cmd      (cmd),
    .opnd     (opnd)
  );

  alu_exec exec_i (
    .opcode (cmd.opcode),
    .opnd   (opnd),
    .value  (value)
  );

  alu_flag_gen flag_i (
    .opcode (cmd.opcode),
    .opnd   (opnd),
    .value  (value),
    .flags  (flags)
  );

  always_ff @(posedge clk) begin
    if (!rst) begin
      result_q <= '0;
    end else if (launch) begin
      result_q.value <= value;  // held until next launch
      result_q.flags <= flags;
    end
  end

  assign result = result_q;

endmodule

//--- hw/alu_flag_gen.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_flag_gen (
  input  alu_pkg::alu_opcode_e opcode,
  input  alu_pkg::alu_opnd_t   opnd,
  input  logic [`ALU_DW-1:0]   value,
  output alu_pkg::alu_flags_t  flags
);
  import alu_pkg::*;

  logic same_sign;
  logic ovf;

  // one of a, b is always the reference operand, the other the selected register
  assign same_sign = (opnd.a[`ALU_DW-1] == opnd.b[`ALU_DW-1]);
  assign ovf       = same_sign && (value[`ALU_DW-1] != opnd.ref_sign);

  always_comb begin
    flags.zero     = (value == '0);
    flags.negative = value[`ALU_DW-1];
    case (opcode)
      op_add, op_mul, op_inc: begin
        flags.overflow = ovf;
        flags.carry    = (value < opnd.ref_val);  // carry
      end
      op_sub, op_cmp, op_dec: begin
        flags.overflow = ovf;
        flags.carry    = (value > opnd.ref_val);  // borrow
      end
      default: begin
        flags.overflow = 1'b0;  // shifts
        flags.carry    = 1'b0;
      end
    endcase
  end

endmodule

//--- hw/alu_exec.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_exec (
  input  alu_pkg::alu_opcode_e opcode,
  input  alu_pkg::alu_opnd_t   opnd,
  output logic [`ALU_DW-1:0]   value
);
  import alu_pkg::*;

  logic [2*`ALU_DW-1:0] product;
  logic [`ALU_DW-1:0]   sum;
  logic [`ALU_DW-1:0]   diff;

  assign product = opnd.a * opnd.b;
  assign sum     = opnd.a + opnd.b;
  assign diff    = opnd.a - opnd.b;

  always_comb begin
    case (opcode)
      op_add, op_inc:         value = sum;
      op_sub, op_cmp, op_dec: value = diff;
      op_shr:                 value = opnd.a >> opnd.b;  // large counts give 0
      op_shl:                 value = opnd.a << opnd.b;
      op_mul:                 value = product[`ALU_DW-1:0];  // low half only
      default:                value = '0;
    endcase
  end

endmodule

//--- hw/alu_operand_select.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_operand_select (
  input  alu_pkg::alu_operands_t operands,
  input  alu_pkg::alu_cmd_t      cmd,
  output alu_pkg::alu_opnd_t     opnd
);
  import alu_pkg::*;

  logic               imm_zero;
  logic [`ALU_DW-1:0] sel_b;
  logic [`ALU_DW-1:0] first;

  assign imm_zero = (operands.imm == '0);
  assign sel_b    = cmd.ra ? operands.y : operands.x;
  assign first    = imm_zero ? operands.acc : operands.imm;

  always_comb begin
    opnd.ref_val  = first;
    opnd.ref_sign = first[`ALU_DW-1];
    case (cmd.opcode)
      op_add, op_mul: begin
        opnd.a = first;
        opnd.b = sel_b;
      end
      op_sub, op_cmp, op_shr, op_shl: begin
        if (imm_zero) begin
          opnd.a = operands.acc;
          opnd.b = sel_b;
        end else begin
          opnd.a = sel_b;  // register first, imm second
          opnd.b = operands.imm;
        end
      end
      op_inc, op_dec: begin
        opnd.a        = sel_b;
        opnd.b        = `ALU_DW'd1;
        opnd.ref_val  = `ALU_DW'd1;  // reference is the constant
        opnd.ref_sign = 1'b0;
      end
      default: begin
        opnd.a = first;
        opnd.b = sel_b;
      end
    endcase
  end

endmodule

//--- hw/alu_apb_regs.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_apb_regs (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`ALU_APB_AW-1:0] paddr,
  input  logic [`ALU_APB_DW-1:0] pwdata,
  output logic [`ALU_APB_DW-1:0] prdata,
  output logic                   pready,
  output logic                   pslverr,
  output alu_pkg::alu_operands_t operands,
  output alu_pkg::alu_cmd_t      cmd,
  output logic                   launch,
  input  alu_pkg::alu_result_t   result
);
  import alu_pkg::*;

  logic          access;
  logic          wr_access;
  logic          rd_access;
  logic          addr_hit;
  logic          addr_ro;
  logic          cmd_wr;
  logic          op_ok;
  alu_operands_t opnd_q;
  alu_cmd_t      cmd_q;
  alu_cmd_t      cmd_new;

  assign access    = psel && penable;  // access phase
  assign wr_access = access && pwrite;
  assign rd_access = access && !pwrite;

  always_comb begin
    addr_hit = 1'b1;
    addr_ro  = 1'b0;
    case (paddr)
      `ALU_REG_ACC, `ALU_REG_X, `ALU_REG_Y, `ALU_REG_IMM, `ALU_REG_CMD: addr_ro = 1'b0;
      `ALU_REG_RESULT, `ALU_REG_FLAGS: addr_ro = 1'b1;
      default: addr_hit = 1'b0;
    endcase
  end

  assign cmd_new.opcode = alu_opcode_e'(pwdata[5:0]);
  assign cmd_new.ra     = pwdata[`ALU_CMD_RA_BIT];

  always_comb begin
    case (cmd_new.opcode)
      op_add, op_sub, op_shr, op_shl, op_mul, op_cmp, op_inc, op_dec: op_ok = 1'b1;
      default: op_ok = 1'b0;  // div/mod and anything else
    endcase
  end

  assign cmd_wr  = wr_access && (paddr == `ALU_REG_CMD);
  assign launch  = cmd_wr && op_ok;
  assign pready  = 1'b1;  // no wait states
  assign pslverr = access && (!addr_hit || (pwrite && addr_ro) || (cmd_wr && !op_ok));

  always_ff @(posedge clk) begin
    if (!rst) begin
      opnd_q <= '0;
      cmd_q  <= '0;
    end else if (wr_access) begin
      case (paddr)
        `ALU_REG_ACC: opnd_q.acc <= pwdata[`ALU_DW-1:0];
        `ALU_REG_X:   opnd_q.x   <= pwdata[`ALU_DW-1:0];
        `ALU_REG_Y:   opnd_q.y   <= pwdata[`ALU_DW-1:0];
        `ALU_REG_IMM: opnd_q.imm <= pwdata[`ALU_DW-1:0];
        `ALU_REG_CMD: begin
          if (op_ok) begin
            cmd_q <= cmd_new;
          end
        end
        default: ;
      endcase
    end
  end

  // readback mux, zero outside read access
  always_comb begin
    prdata = '0;
    if (rd_access) begin
      case (paddr)
        `ALU_REG_ACC:    prdata[`ALU_DW-1:0] = opnd_q.acc;
        `ALU_REG_X:      prdata[`ALU_DW-1:0] = opnd_q.x;
        `ALU_REG_Y:      prdata[`ALU_DW-1:0] = opnd_q.y;
        `ALU_REG_IMM:    prdata[`ALU_DW-1:0] = opnd_q.imm;
        `ALU_REG_CMD: begin
          prdata[5:0]             = cmd_q.opcode;
          prdata[`ALU_CMD_RA_BIT] = cmd_q.ra;
        end
        `ALU_REG_RESULT: prdata[`ALU_DW-1:0] = result.value;
        `ALU_REG_FLAGS:  prdata[3:0]         = result.flags;
        default:         prdata              = '0;
      endcase
    end
  end

  assign operands = opnd_q;
  // the new command goes straight to the core in the launch cycle
  assign cmd      = launch ? cmd_new : cmd_q;

endmodule

//--- hw/alu_pkg.sv
`include "alu_consts.svh"

package alu_pkg;

  typedef enum logic [5:0] {
    op_add = `ALU_OP_ADD,
    op_sub = `ALU_OP_SUB,
    op_shr = `ALU_OP_SHR,
    op_shl = `ALU_OP_SHL,
    op_mul = `ALU_OP_MUL,
    op_cmp = `ALU_OP_CMP,
    op_inc = `ALU_OP_INC,
    op_dec = `ALU_OP_DEC
  } alu_opcode_e;

  typedef struct packed {
    logic [`ALU_DW-1:0] acc;
    logic [`ALU_DW-1:0] x;
    logic [`ALU_DW-1:0] y;
    logic [`ALU_DW-1:0] imm;
  } alu_operands_t;

  typedef struct packed {
    alu_opcode_e opcode;
    logic        ra;  // 0 picks x, 1 picks y
  } alu_cmd_t;

  // overflow ends up in bit 0, zero in bit 3
  typedef struct packed {
    logic zero;
    logic negative;
    logic carry;  // borrow for subtract class
    logic overflow;
  } alu_flags_t;

  typedef struct packed {
    logic [`ALU_DW-1:0] a;
    logic [`ALU_DW-1:0] b;
    logic [`ALU_DW-1:0] ref_val;  // value before the operation
    logic               ref_sign;
  } alu_opnd_t;

  typedef struct packed {
    logic [`ALU_DW-1:0] value;
    alu_flags_t         flags;
  } alu_result_t;

endpackage

//--- hw/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// widths
`define ALU_DW          16
`define ALU_APB_AW      8
`define ALU_APB_DW      32

// register map, byte offsets
`define ALU_REG_ACC     8'h00
`define ALU_REG_X       8'h04
`define ALU_REG_Y       8'h08
`define ALU_REG_IMM     8'h0C
`define ALU_REG_CMD     8'h10
`define ALU_REG_RESULT  8'h14
`define ALU_REG_FLAGS   8'h18

// ra position in the command word, opcode sits in [5:0]
`define ALU_CMD_RA_BIT  8

// kept opcodes
`define ALU_OP_ADD      6'h0D
`define ALU_OP_SUB      6'h0E
`define ALU_OP_SHR      6'h0F
`define ALU_OP_SHL      6'h10
`define ALU_OP_MUL      6'h11
`define ALU_OP_CMP      6'h14
`define ALU_OP_INC      6'h15
`define ALU_OP_DEC      6'h16

`endif
